//--- src/sha3pad_pkg.sv
// Shared widths, encodings and constant functions for the SHA3 pad front end
// Message path is fixed at 64 bits, rates are counted in 64-bit words
// rate_words returns 0 for an unused strength code

package sha3pad_pkg;

  // Message word geometry
  localparam int MsgWidth   = 64;
  localparam int MsgStrbW   = MsgWidth / 8;
  // Largest rate is 168 bytes (L128)
  localparam int MsgEntries = 21;
  localparam int MsgCntW    = 5;

  typedef enum logic [1:0] {
    Sha3,
    Shake,
    CShake
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128,
    L224,
    L256,
    L384,
    L512
  } strength_e;

  // Source of the word written into the block buffer
  typedef enum logic [2:0] {
    SelNone,
    SelMsg,
    SelPrefix,
    SelFuncPad,
    SelZeroEnd
  } pad_sel_e;

  // Block size in 64-bit words
  function automatic logic [MsgCntW-1:0] rate_words(strength_e s);
    unique case (s)
      L128:    return MsgCntW'(21);
      L224:    return MsgCntW'(18);
      L256:    return MsgCntW'(17);
      L384:    return MsgCntW'(13);
      L512:    return MsgCntW'(9);
      default: return '0;
    endcase
  endfunction

  // Domain bits plus the first 1 of pad10*1, LSB first
  function automatic logic [4:0] funcpad_bits(sha3_mode_e m);
    unique case (m)
      Sha3:    return 5'b00110;
      Shake:   return 5'b11111;
      CShake:  return 5'b00100;
      // Only the pad10*1 leading one
      default: return 5'b00001;
    endcase
  endfunction

endpackage

//--- src/pad_wr_if.sv
// Write port of the block buffer as seen by the pad controller
// Controller owns the write strobes, buffer reports its fill position

`timescale 1ns/1ps

interface pad_wr_if
  import sha3pad_pkg::*;
();

  // Write side
  pad_sel_e           sel;
  logic               wr_en;
  logic               clr;

  // Fill status
  // Next write lands in the last word of the block
  logic               end_of_block;
  // Counter has reached the rate
  logic               block_full;
  logic [MsgCntW-1:0] wr_idx;

  modport ctrl (
    output sel, wr_en, clr,
    input  end_of_block, block_full, wr_idx
  );

  modport buffer (
    input  sel, wr_en, clr,
    output end_of_block, block_full, wr_idx
  );

endinterface

//--- src/pad_ctrl.sv
// Padding FSM: prefix, message, function pad, zero fill and block runs
// start_i and process_i are single-cycle pulses and never coincide
// One block in flight at a time, a run waits for the previous complete

`timescale 1ns/1ps

module pad_ctrl
  import sha3pad_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_b,
  input  logic       start_i,
  input  logic       process_i,
  input  sha3_mode_e mode_i,
  input  logic       msg_valid_i,
  input  logic       msg_partial_i,
  input  logic       keccak_ready_i,
  input  logic       keccak_complete_i,
  output logic       msg_ready_o,
  output logic       keccak_run_o,
  output logic       absorbed_o,
  output logic       latch_partial_o,
  output logic       clr_partial_o,
  pad_wr_if.ctrl     wr
);

  typedef enum logic [2:0] {
    Idle,
    Prefix,
    PrefixWait,
    Message,
    Pad,
    PadRun,
    Pad01,
    Flush
  } pad_st_e;

  pad_st_e state_q, state_d;
  logic    process_q;
  logic    busy_q;
  logic    absorbed_d;
  logic    run_ok;

  // Permutation accepts a run only when ready and idle
  assign run_ok = keccak_ready_i && !busy_q;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      state_q    <= Idle;
      process_q  <= 1'b0;
      busy_q     <= 1'b0;
      absorbed_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      absorbed_o <= absorbed_d;
      // process may arrive while a block is still pending
      if (process_i) begin
        process_q <= 1'b1;
      end else if (start_i) begin
        process_q <= 1'b0;
      end
      // Block in flight between run and complete
      if (keccak_run_o) begin
        busy_q <= 1'b1;
      end else if (keccak_complete_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    wr.sel          = SelNone;
    wr.wr_en        = 1'b0;
    wr.clr          = 1'b0;
    msg_ready_o     = 1'b0;
    keccak_run_o    = 1'b0;
    latch_partial_o = 1'b0;
    clr_partial_o   = 1'b0;
    absorbed_d      = 1'b0;

    unique case (state_q)
      Idle: begin
        if (start_i) begin
          // cSHAKE sends the bytepad prefix block first
          state_d = (mode_i == CShake) ? Prefix : Message;
        end
      end

      Prefix: begin
        wr.sel = SelPrefix;
        if (!wr.block_full) begin
          wr.wr_en = 1'b1;
        end else if (run_ok) begin
          keccak_run_o = 1'b1;
          wr.clr       = 1'b1;
          state_d      = PrefixWait;
        end
      end

      PrefixWait: begin
        if (keccak_complete_i) begin
          state_d = Message;
        end
      end

      Message: begin
        wr.sel = SelMsg;
        if (wr.block_full) begin
          // Full block goes out before process is looked at
          if (run_ok) begin
            keccak_run_o = 1'b1;
            wr.clr       = 1'b1;
          end
        end else if (process_q || process_i) begin
          state_d = Pad;
        end else begin
          msg_ready_o = 1'b1;
          // Partial word ends the message, kept aside for the pad word
          wr.wr_en        = msg_valid_i && !msg_partial_i;
          latch_partial_o = msg_valid_i && msg_partial_i;
        end
      end

      Pad: begin
        wr.sel = SelFuncPad;
        if (keccak_ready_i) begin
          wr.wr_en      = 1'b1;
          clr_partial_o = 1'b1;
          // End bit already merged when the pad word closes the block
          state_d = wr.end_of_block ? PadRun : Pad01;
        end
      end

      PadRun: begin
        if (run_ok) begin
          keccak_run_o = 1'b1;
          wr.clr       = 1'b1;
          state_d      = Flush;
        end
      end

      Pad01: begin
        wr.sel = SelZeroEnd;
        if (wr.block_full) begin
          if (run_ok) begin
            keccak_run_o = 1'b1;
            wr.clr       = 1'b1;
            state_d      = Flush;
          end
        end else if (keccak_ready_i) begin
          wr.wr_en = 1'b1;
        end
      end

      Flush: begin
        // Only the last block is in flight here
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          state_d    = Idle;
        end
      end

      default: begin
        state_d = Idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  run_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_o |=> !keccak_run_o)
    else $error("keccak_run_o held longer than one cycle");

  start_process_excl_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    !(start_i && process_i))
    else $error("start_i and process_i high together");

  // Buffer must drain before any further write
  no_wr_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    wr.block_full |-> !wr.wr_en)
    else $error("Block write while block_full");

endmodule

//--- src/prefix_gen.sv
// cSHAKE bytepad prefix: left_encode(rate) then the N/S string, zero filled
// ns_data_i is prepared by software as encode_string(N) || encode_string(S)
// The whole prefix must fit below 136 bytes

`timescale 1ns/1ps

module prefix_gen
  import sha3pad_pkg::*;
#(
  parameter int NsBytes = 30
) (
  input  logic [NsBytes*8-1:0] ns_data_i,
  input  strength_e            strength_i,
  input  logic [MsgCntW-1:0]   wr_idx_i,
  output logic [MsgWidth-1:0]  prefix_word_o
);

  // One full-rate block of prefix words
  logic [MsgEntries-1:0][MsgWidth-1:0] prefix_words;
  logic [7:0]                          rate_bytes;

  // Rate in bytes, 168 at most
  assign rate_bytes = {rate_words(strength_i), 3'b000};

  // Byte 0 is the left_encode length byte, byte 1 the rate
  assign prefix_words = (MsgEntries*MsgWidth)'({ns_data_i, rate_bytes, 8'h01});

  // Index equals the rate once the block is full
  assign prefix_word_o = (wr_idx_i < MsgCntW'(MsgEntries)) ? prefix_words[wr_idx_i] : '0;

  ////////////////////////////////////////////////////////////
  // Elaboration checks
  ////////////////////////////////////////////////////////////

  if (NsBytes + 2 >= 136) begin : g_prefix_too_long
    $error("Prefix of %0d bytes does not fit the block", NsBytes + 2);
  end

endmodule

//--- src/funcpad_gen.sv
// Function pad word: kept bytes of a partial last word, pad bits, end bit
// A partial word has its top strobe low and contiguous strobes from byte 0
// The latched bytes stay until clr_i after the pad word is written

`timescale 1ns/1ps

module funcpad_gen
  import sha3pad_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_b,
  input  logic [MsgWidth-1:0] msg_data_i,
  input  logic [MsgStrbW-1:0] msg_strb_i,
  input  logic                latch_i,
  input  logic                clr_i,
  input  sha3_mode_e          mode_i,
  input  logic                end_of_block_i,
  output logic                msg_partial_o,
  output logic [MsgWidth-1:0] pad_word_o
);

  localparam int KeepW = MsgWidth - 8;
  localparam int CntW  = $clog2(MsgStrbW);

  logic [KeepW-1:0] kept_bytes;
  logic [KeepW-1:0] keep_q;
  logic [CntW-1:0]  cnt_q;

  // Top byte missing means the word is partial
  assign msg_partial_o = !msg_strb_i[MsgStrbW-1];

  // Zero the bytes without strobe before they are kept
  always_comb begin
    kept_bytes = '0;
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      if (msg_strb_i[i]) begin
        kept_bytes[8*i +: 8] = msg_data_i[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_b || clr_i) begin
      keep_q <= '0;
      cnt_q  <= '0;
    end else if (latch_i) begin
      keep_q <= kept_bytes;
      cnt_q  <= CntW'($countones(msg_strb_i[MsgStrbW-2:0]));
    end
  end

  // Pad byte directly after the last kept byte
  always_comb begin
    pad_word_o = {8'h00, keep_q} | (MsgWidth'(funcpad_bits(mode_i)) << {cnt_q, 3'b000});
    // pad10*1 closing bit when this word ends the block
    pad_word_o[MsgWidth-1] = pad_word_o[MsgWidth-1] | end_of_block_i;
  end

  // Controller only latches words this module flags as partial
  latch_partial_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    latch_i |-> msg_partial_o)
    else $error("Full word latched as partial, strb=%h", msg_strb_i);

endmodule

//--- src/block_buffer.sv
// Rate-sized block storage feeding the permutation state
// Words beyond the rate stay zero, word 0 sits in the low bits
// Output is registered, a write shows one cycle after wr_en

`timescale 1ns/1ps

module block_buffer
  import sha3pad_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_b,
  input  strength_e                           strength_i,
  input  logic [MsgWidth-1:0]                 msg_data_i,
  input  logic [MsgWidth-1:0]                 prefix_word_i,
  input  logic [MsgWidth-1:0]                 pad_word_i,
  output logic [MsgEntries-1:0][MsgWidth-1:0] keccak_data_o,
  pad_wr_if.buffer                            wr
);

  logic [MsgCntW-1:0]                  rate;
  logic [MsgCntW-1:0]                  cnt_q;
  logic [MsgWidth-1:0]                 wr_data;
  logic [MsgEntries-1:0][MsgWidth-1:0] mem_q;

  assign rate = rate_words(strength_i);

  // Fill status towards the controller
  assign wr.wr_idx       = cnt_q;
  assign wr.block_full   = (cnt_q == rate);
  assign wr.end_of_block = ((cnt_q + MsgCntW'(1)) == rate);

  ////////////////////////////////////////////////////////////
  // Source mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (wr.sel)
      SelMsg:     wr_data = msg_data_i;
      SelPrefix:  wr_data = prefix_word_i;
      SelFuncPad: wr_data = pad_word_i;
      // Zero fill, last word carries the pad10*1 end bit
      SelZeroEnd: wr_data = {wr.end_of_block, {(MsgWidth-1){1'b0}}};
      default:    wr_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counter and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_b || wr.clr) begin
      cnt_q <= '0;
    end else if (wr.wr_en) begin
      cnt_q <= cnt_q + MsgCntW'(1);
    end
  end

  // Unwritten words must read as zero in every block
  always_ff @(posedge clk_i) begin
    if (!rst_b || wr.clr) begin
      mem_q <= '0;
    end else if (wr.wr_en) begin
      mem_q[wr.wr_idx] <= wr_data;
    end
  end

  assign keccak_data_o = mem_q;

  wr_in_rate_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    wr.wr_en |-> (wr.wr_idx < rate))
    else $error("Write index %h outside rate %h", wr.wr_idx, rate);

endmodule

//--- src/sha3pad_top.sv
// SHA3 pad front end with plain ports
// mode_i, strength_i and ns_data_i must stay stable from start_i to absorbed_o
// cSHAKE is meant for L128 and L256 only, the prefix must fit the rate

`timescale 1ns/1ps

module sha3pad_top
  import sha3pad_pkg::*;
#(
  parameter int NsBytes = 30
) (
  input  logic                                clk_i,
  input  logic                                rst_b,
  // Message stream
  input  logic                                msg_valid_i,
  input  logic [MsgWidth-1:0]                 msg_data_i,
  input  logic [MsgStrbW-1:0]                 msg_strb_i,
  output logic                                msg_ready_o,
  // Configuration
  input  logic [NsBytes*8-1:0]                ns_data_i,
  input  sha3_mode_e                          mode_i,
  input  strength_e                           strength_i,
  input  logic                                start_i,
  input  logic                                process_i,
  // Permutation side
  output logic [MsgEntries-1:0][MsgWidth-1:0] keccak_data_o,
  input  logic                                keccak_ready_i,
  output logic                                keccak_run_o,
  input  logic                                keccak_complete_i,
  output logic                                absorbed_o
);

  logic                msg_partial;
  logic                latch_partial;
  logic                clr_partial;
  logic [MsgWidth-1:0] prefix_word;
  logic [MsgWidth-1:0] pad_word;

  pad_wr_if u_wr_if ();

  pad_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .start_i           (start_i),
    .process_i         (process_i),
    .mode_i            (mode_i),
    .msg_valid_i       (msg_valid_i),
    .msg_partial_i     (msg_partial),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .msg_ready_o       (msg_ready_o),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .latch_partial_o   (latch_partial),
    .clr_partial_o     (clr_partial),
    .wr                (u_wr_if.ctrl)
  );

  prefix_gen #(
    .NsBytes (NsBytes)
  ) u_prefix (
    .ns_data_i     (ns_data_i),
    .strength_i    (strength_i),
    .wr_idx_i      (u_wr_if.wr_idx),
    .prefix_word_o (prefix_word)
  );

  funcpad_gen u_funcpad (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .msg_data_i     (msg_data_i),
    .msg_strb_i     (msg_strb_i),
    .latch_i        (latch_partial),
    .clr_i          (clr_partial),
    .mode_i         (mode_i),
    .end_of_block_i (u_wr_if.end_of_block),
    .msg_partial_o  (msg_partial),
    .pad_word_o     (pad_word)
  );

  block_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .strength_i    (strength_i),
    .msg_data_i    (msg_data_i),
    .prefix_word_i (prefix_word),
    .pad_word_i    (pad_word),
    .keccak_data_o (keccak_data_o),
    .wr            (u_wr_if.buffer)
  );

endmodule

//--- tests/tb_model.svh
// Reference model, random source and compare tasks for the SHA3 pad testbench
// Included inside tb_sha3pad, uses its error counters and block queues
// Rates and pad bytes are written out here from the SHA3 rules

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// xorshift32, state starts from the seed
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Rate in bytes for a strength
function automatic int rate_bytes_of(strength_e s);
  case (s)
    L128:    return 168;
    L224:    return 144;
    L256:    return 136;
    L384:    return 104;
    default: return 72;
  endcase
endfunction

// Domain bits plus first pad10*1 bit, as one byte
function automatic logic [7:0] pad_byte_of(sha3_mode_e m);
  case (m)
    Sha3:    return 8'h06;
    Shake:   return 8'h1f;
    default: return 8'h04;
  endcase
endfunction

// Byte stream into one block, byte 0 in the low bits of word 0
task automatic push_stream_blocks(input logic [7:0] stream[$], input int rb);
  block_t blk;
  for (int i = 0; i < stream.size(); i += rb) begin
    blk = '0;
    for (int j = 0; j < rb; j++) begin
      blk[j/8][8*(j%8) +: 8] = stream[i+j];
    end
    exp_q.push_back(blk);
  end
endtask

// cSHAKE prefix block, left_encode(rate) then N/S, zero filled
task automatic push_prefix_block(input strength_e s);
  logic [7:0] stream[$];
  int         rb;
  rb = rate_bytes_of(s);
  stream.push_back(8'h01);
  stream.push_back(8'(rb));
  for (int i = 0; i < NsBytes; i++) begin
    stream.push_back(ns_data_i[8*i +: 8]);
  end
  while (stream.size() < rb) begin
    stream.push_back(8'h00);
  end
  push_stream_blocks(stream, rb);
endtask

// Message, pad byte, zero fill, end bit in the last byte of the last block
task automatic push_message_blocks(input sha3_mode_e m, input strength_e s,
                                   input logic [7:0] msg[$]);
  logic [7:0] stream[$];
  int         rb;
  rb = rate_bytes_of(s);
  stream = msg;
  stream.push_back(pad_byte_of(m));
  while ((stream.size() % rb) != 0) begin
    stream.push_back(8'h00);
  end
  stream[stream.size()-1] = stream[stream.size()-1] | 8'h80;
  push_stream_blocks(stream, rb);
endtask

// One error per wrong block, every wrong word shown
task automatic check_block(input string name, input block_t got, input block_t exp);
  if (got !== exp) begin
    value_err++;
    for (int w = 0; w < MsgEntries; w++) begin
      if (got[w] !== exp[w]) begin
        $display("** Error %s word %0d: got %h, expected %h", name, w, got[w], exp[w]);
      end
    end
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    value_err++;
    $display("** Error %s: got %h, expected %h", name, got, exp);
  end
endtask

`endif

//--- tests/tb_sha3pad.sv
// Testbench for sha3pad_top with a random permutation responder
// Inputs change on the falling edge, results are sampled on the rising edge
// cSHAKE runs use L128 and L256 only, as the prefix needs a wide rate

`timescale 1ns/1ps

module tb_sha3pad
  import sha3pad_pkg::*;
();

  localparam int NsBytes  = 30;
  localparam int WaitMax  = 400;
  localparam int HalfPer  = 20;

  typedef logic [MsgEntries-1:0][MsgWidth-1:0] block_t;

  logic                 clk_i;
  logic                 rst_b;
  logic                 msg_valid_i;
  logic [MsgWidth-1:0]  msg_data_i;
  logic [MsgStrbW-1:0]  msg_strb_i;
  logic                 msg_ready_o;
  logic [NsBytes*8-1:0] ns_data_i;
  sha3_mode_e           mode_i;
  strength_e            strength_i;
  logic                 start_i;
  logic                 process_i;
  block_t               keccak_data_o;
  logic                 keccak_ready_i;
  logic                 keccak_run_o;
  logic                 keccak_complete_i;
  logic                 absorbed_o;

  int          value_err;
  int          other_err;
  int          absorb_cnt;
  int          pend_cnt;
  logic        ready_draw;
  logic        cmpl_prev;
  logic [31:0] rng_state;
  block_t      exp_q[$];
  block_t      got_q[$];

  `include "tb_model.svh"

  sha3pad_top #(
    .NsBytes (NsBytes)
  ) u_dut (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .msg_valid_i       (msg_valid_i),
    .msg_data_i        (msg_data_i),
    .msg_strb_i        (msg_strb_i),
    .msg_ready_o       (msg_ready_o),
    .ns_data_i         (ns_data_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .keccak_data_o     (keccak_data_o),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_run_o      (keccak_run_o),
    .keccak_complete_i (keccak_complete_i),
    .absorbed_o        (absorbed_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #HalfPer clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Permutation model
  ////////////////////////////////////////////////////////////

  // Block capture, complete countdown and the next ready draw
  always @(posedge clk_i) begin
    if (rst_b) begin
      if (keccak_run_o) begin
        got_q.push_back(keccak_data_o);
        pend_cnt = 3 + int'(next_rand() % 8);
      end else if (pend_cnt > 0) begin
        pend_cnt--;
      end
      ready_draw = (next_rand() % 4) != 0;
      if (absorbed_o) begin
        absorb_cnt++;
        // Final complete one cycle earlier, no block left in flight
        if (!cmpl_prev || (pend_cnt != 0)) begin
          other_err++;
          $display("absorbed_o did not follow the final keccak_complete_i by one cycle");
        end
      end
      cmpl_prev = keccak_complete_i;
    end
  end

  // Complete pulse and random stalls
  always @(negedge clk_i) begin
    if (rst_b) begin
      keccak_complete_i = (pend_cnt == 1);
      keccak_ready_i    = ready_draw;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic report_counts();
    $display("Errors: %0d wrong values, %0d other failures", value_err, other_err);
  endtask

  task automatic abort_on_timeout(input string what);
    other_err++;
    $display("Timeout while waiting for %s", what);
    report_counts();
    $display("Checks failed");
    $finish;
  endtask

  // Holds the word until it transfers, returns on the falling edge
  task automatic wait_accept();
    int t;
    bit done;
    t = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (msg_ready_o) begin
        done = 1'b1;
      end else begin
        t++;
        if (t > WaitMax) begin
          abort_on_timeout("msg_ready_o");
        end
      end
    end
    @(negedge clk_i);
  endtask

  task automatic wait_absorbed();
    int t;
    bit done;
    t = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (absorbed_o) begin
        done = 1'b1;
      end else begin
        t++;
        if (t > WaitMax) begin
          abort_on_timeout("absorbed_o");
        end
      end
    end
  endtask

  // Full hash: start, words, process, then compare every run block
  task automatic hash_message(input sha3_mode_e m, input strength_e s, input int nbytes,
                              input bit zero_tail);
    logic [7:0] msg[$];
    int         nwords;
    int         kept;
    int         c0;
    int         n;
    msg = {};
    for (int i = 0; i < nbytes; i++) begin
      msg.push_back(8'(next_rand() >> 8));
    end
    exp_q = {};
    got_q = {};
    if (m == CShake) begin
      push_prefix_block(s);
    end
    push_message_blocks(m, s, msg);
    c0 = absorb_cnt;

    @(negedge clk_i);
    mode_i     = m;
    strength_i = s;
    start_i    = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;

    // Strobe 0 word closes a message of whole words
    nwords = (nbytes + 7) / 8;
    if (zero_tail && (nbytes % 8 == 0)) begin
      nwords++;
    end
    for (int w = 0; w < nwords; w++) begin
      kept = nbytes - 8*w;
      if (kept > 8) begin
        kept = 8;
      end
      msg_data_i = {next_rand(), next_rand()};
      msg_strb_i = '0;
      for (int b = 0; b < kept; b++) begin
        msg_strb_i[b]          = 1'b1;
        msg_data_i[8*b +: 8]   = msg[8*w + b];
      end
      msg_valid_i = 1'b1;
      wait_accept();
    end
    msg_valid_i = 1'b0;
    msg_data_i  = '0;
    msg_strb_i  = '0;
    process_i   = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;

    wait_absorbed();
    repeat (4) @(negedge clk_i);
    if (absorb_cnt != c0 + 1) begin
      other_err++;
      $display("Expected one absorbed pulse, saw %0d", absorb_cnt - c0);
    end
    check_bit("msg_ready_o", msg_ready_o, 1'b0);

    if (got_q.size() != exp_q.size()) begin
      other_err++;
      $display("Run count wrong, %0d runs for %0d expected blocks", got_q.size(),
               exp_q.size());
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_block($sformatf("keccak_data_o block %0d", i), got_q[i], exp_q[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    value_err         = 0;
    other_err         = 0;
    absorb_cnt        = 0;
    pend_cnt          = 0;
    ready_draw        = 1'b1;
    cmpl_prev         = 1'b0;
    rng_state         = 32'd47;
    rst_b             = 1'b0;
    msg_valid_i       = 1'b0;
    msg_data_i        = '0;
    msg_strb_i        = '0;
    mode_i            = Sha3;
    strength_i        = L256;
    start_i           = 1'b0;
    process_i         = 1'b0;
    keccak_ready_i    = 1'b1;
    keccak_complete_i = 1'b0;
    for (int i = 0; i < NsBytes; i++) begin
      ns_data_i[8*i +: 8] = 8'(next_rand() >> 4);
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_b = 1'b1;
    check_bit("keccak_run_o", keccak_run_o, 1'b0);
    check_bit("msg_ready_o", msg_ready_o, 1'b0);
    check_bit("absorbed_o", absorbed_o, 1'b0);

    // Short Sha3 messages, every strength
    for (int s = 0; s < 5; s++) begin
      hash_message(Sha3, strength_e'(s), rate_bytes_of(strength_e'(s)) / 2 +
                   int'(next_rand() % 8), 1'b0);
    end

    // Shake over several blocks
    hash_message(Shake, L256, 2*136 + 37, 1'b0);
    hash_message(Shake, L128, 168 + 90, 1'b0);

    // cSHAKE with prefix block
    hash_message(CShake, L128, 50, 1'b0);
    hash_message(CShake, L256, 200, 1'b0);

    // Partial last word, strobe counts 0 to 7
    for (int k = 0; k < 8; k++) begin
      hash_message(Sha3, L512, 16 + k, 1'b1);
    end

    // Message ends on a block boundary
    hash_message(Shake, L384, 104, 1'b0);
    hash_message(Sha3, L128, 168, 1'b0);
    hash_message(Sha3, L512, 144, 1'b1);

    report_counts();
    if (value_err + other_err == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- all.f
src/sha3pad_pkg.sv
src/pad_wr_if.sv
src/pad_ctrl.sv
src/prefix_gen.sv
src/funcpad_gen.sv
src/block_buffer.sv
src/sha3pad_top.sv
+incdir+tests
tests/tb_sha3pad.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_sha3pad \
		-o tb_sha3pad

run: compile
	./obj_dir/tb_sha3pad > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
